//--- hdl/rd_demux_pkg.sv
// default sizes shared by the read demultiplexer blocks
// fixed AR burst length width
// helper constants for the per-ID in-flight counters

package rd_demux_pkg;

  // ------------------------------------------------
  // default sizes, overridden from the top level
  // ------------------------------------------------
  // master ports behind the demux
  localparam int unsigned NUM_MST_PORTS_DEF = 4;
  // full AR and R ID width
  localparam int unsigned ID_WIDTH_DEF      = 4;
  // low ID bits tracked by the table, one counter per value
  localparam int unsigned LOOK_BITS_DEF     = 2;
  // in-flight counter width per tracked ID
  localparam int unsigned CNT_WIDTH_DEF     = 3;
  localparam int unsigned ADDR_WIDTH_DEF    = 32;
  localparam int unsigned DATA_WIDTH_DEF    = 32;

  // AXI burst length field, not configurable
  localparam int unsigned LEN_WIDTH = 8;

  // ------------------------------------------------
  // counter helpers
  // ------------------------------------------------
  // reads issued by one push or retired by one pop
  localparam int unsigned CNT_STEP         = 1;
  // outstanding reads per ID before the table reports full
  localparam int unsigned MAX_INFLIGHT_DEF = (1 << CNT_WIDTH_DEF) - 1;
  // narrowest select or grant index, also used with a single port
  localparam int unsigned SEL_WIDTH_MIN    = 1;

endpackage

//--- hdl/ar_dispatch.sv
// AR admission check against the per-ID in-flight table
// valid lock held until the chosen master accepts
// payload broadcast and one-hot valid towards the master ports

`timescale 1ns/1ps

module ar_dispatch #(
  parameter int unsigned NumMstPorts = rd_demux_pkg::NUM_MST_PORTS_DEF,
  parameter int unsigned IdWidth     = rd_demux_pkg::ID_WIDTH_DEF,
  parameter int unsigned AddrWidth   = rd_demux_pkg::ADDR_WIDTH_DEF,
  localparam int unsigned SelWidth   = (NumMstPorts > 1) ? $clog2(NumMstPorts)
                                                         : rd_demux_pkg::SEL_WIDTH_MIN,
  localparam int unsigned LenWidth   = rd_demux_pkg::LEN_WIDTH
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // slave AR request
  input  logic                              slv_ar_valid_i,
  output logic                              slv_ar_ready_o,
  input  logic [IdWidth-1:0]                slv_ar_id_i,
  input  logic [AddrWidth-1:0]              slv_ar_addr_i,
  input  logic [LenWidth-1:0]               slv_ar_len_i,
  input  logic [SelWidth-1:0]               slv_ar_select_i,
  // ID table lookup and update
  input  logic [SelWidth-1:0]               lookup_sel_i,
  input  logic                              lookup_busy_i,
  input  logic                              full_i,
  output logic                              push_o,
  // master AR ports, one slice each
  output logic [NumMstPorts-1:0]            mst_ar_valid_o,
  input  logic [NumMstPorts-1:0]            mst_ar_ready_i,
  output logic [NumMstPorts*IdWidth-1:0]    mst_ar_id_o,
  output logic [NumMstPorts*AddrWidth-1:0]  mst_ar_addr_o,
  output logic [NumMstPorts*LenWidth-1:0]   mst_ar_len_o
);
  import rd_demux_pkg::*;

  // admission and handshake
  logic admit;
  logic sel_ready;
  logic ar_valid;
  // valid lock
  logic lock_q;
  logic lock_d;

  // ------------------------------------------------
  // admission
  // ------------------------------------------------
  // free counters, and either an idle ID or the same port as the reads in flight
  assign admit = !full_i && (!lookup_busy_i || (slv_ar_select_i == lookup_sel_i));

  // ready of the port the select names
  always_comb begin
    sel_ready = 1'b0;
    for (int i = 0; i < NumMstPorts; i++) begin
      if (slv_ar_select_i == SelWidth'(i)) begin
        sel_ready = mst_ar_ready_i[i];
      end
    end
  end

  // ------------------------------------------------
  // handshake and valid lock
  // ------------------------------------------------
  always_comb begin
    ar_valid       = 1'b0;
    slv_ar_ready_o = 1'b0;
    push_o         = 1'b0;
    lock_d         = lock_q;
    if (lock_q) begin
      // offered earlier, keep it up regardless of the table
      ar_valid = 1'b1;
      if (sel_ready) begin
        slv_ar_ready_o = 1'b1;
        push_o         = 1'b1;
        lock_d         = 1'b0;
      end
    end else if (slv_ar_valid_i && admit) begin
      ar_valid = 1'b1;
      if (sel_ready) begin
        slv_ar_ready_o = 1'b1;
        push_o         = 1'b1;
      end else begin
        // master stalls, hold the decision
        lock_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

  // ------------------------------------------------
  // master side
  // ------------------------------------------------
  // only the selected port sees valid
  always_comb begin
    for (int i = 0; i < NumMstPorts; i++) begin
      mst_ar_valid_o[i] = ar_valid && (slv_ar_select_i == SelWidth'(i));
    end
  end

  // same payload on every port
  for (genvar i = 0; i < NumMstPorts; i++) begin : gen_ar_payload
    assign mst_ar_id_o[i*IdWidth +: IdWidth]       = slv_ar_id_i;
    assign mst_ar_addr_o[i*AddrWidth +: AddrWidth] = slv_ar_addr_i;
    assign mst_ar_len_o[i*LEN_WIDTH +: LEN_WIDTH]  = slv_ar_len_i;
  end

  // offered valid stays on the same master port until that port took the AR
  a_ar_valid_held : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ar_valid && !sel_ready) |=> (mst_ar_valid_o == $past(mst_ar_valid_o)))
    else $error("AR valid to master dropped without a transfer");

  // select must name an existing port while a request is offered
  a_ar_select_range : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slv_ar_valid_i |-> (slv_ar_select_i < NumMstPorts))
    else $error("AR select %0d beyond the last master port", slv_ar_select_i);

endmodule

//--- hdl/rd_id_table.sv
// per-ID in-flight read counters
// stored master port select for each tracked ID
// lookup of select, busy and full for the AR in front

`timescale 1ns/1ps

module rd_id_table #(
  parameter int unsigned NumMstPorts = rd_demux_pkg::NUM_MST_PORTS_DEF,
  parameter int unsigned LookBits    = rd_demux_pkg::LOOK_BITS_DEF,
  parameter int unsigned CntWidth    = rd_demux_pkg::CNT_WIDTH_DEF,
  localparam int unsigned SelWidth   = (NumMstPorts > 1) ? $clog2(NumMstPorts)
                                                         : rd_demux_pkg::SEL_WIDTH_MIN
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // lookup, also the ID that a push counts up
  input  logic [LookBits-1:0] lookup_id_i,
  output logic [SelWidth-1:0] lookup_sel_o,
  output logic                lookup_busy_o,
  output logic                full_o,
  // AR transfer
  input  logic                push_i,
  input  logic [SelWidth-1:0] push_sel_i,
  // last R beat on the slave side
  input  logic                pop_i,
  input  logic [LookBits-1:0] pop_id_i
);
  import rd_demux_pkg::*;

  localparam int unsigned NumIds = 1 << LookBits;

  // in-flight count and target port per tracked ID
  logic [CntWidth-1:0] cnt_q [NumIds];
  logic [SelWidth-1:0] sel_q [NumIds];
  // per-ID status
  logic [NumIds-1:0]   busy;
  logic [NumIds-1:0]   cnt_full;

  // ------------------------------------------------
  // lookup
  // ------------------------------------------------
  assign lookup_sel_o  = sel_q[lookup_id_i];
  assign lookup_busy_o = busy[lookup_id_i];
  // any saturated counter blocks all new ARs
  assign full_o        = |cnt_full;

  // ------------------------------------------------
  // counters
  // ------------------------------------------------
  for (genvar i = 0; i < NumIds; i++) begin : gen_id
    logic push_hit;
    logic pop_hit;

    assign push_hit = push_i && (lookup_id_i == LookBits'(i));
    assign pop_hit  = pop_i && (pop_id_i == LookBits'(i));

    // push and pop on the same ID cancel out
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        cnt_q[i] <= '0;
      end else if (push_hit && !pop_hit) begin
        cnt_q[i] <= cnt_q[i] + CntWidth'(CNT_STEP);
      end else if (pop_hit && !push_hit) begin
        cnt_q[i] <= cnt_q[i] - CntWidth'(CNT_STEP);
      end
    end

    // port taken on every push, only meaningful while busy
    always_ff @(posedge clk_i) begin
      if (push_hit) begin
        sel_q[i] <= push_sel_i;
      end
    end

    assign busy[i]     = |cnt_q[i];
    assign cnt_full[i] = &cnt_q[i];

    // a last beat must belong to a read that went through the dispatcher
    a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pop_hit |-> (cnt_q[i] != '0))
      else $error("pop on idle ID %0d", i);
  end

endmodule

//--- hdl/r_arbiter.sv
// round-robin arbiter for R beats from the master ports
// grant held while the slave stalls, pointer moves past each winner
// pop of the ID table on every last beat transfer

`timescale 1ns/1ps

module r_arbiter #(
  parameter int unsigned NumMstPorts = rd_demux_pkg::NUM_MST_PORTS_DEF,
  parameter int unsigned IdWidth     = rd_demux_pkg::ID_WIDTH_DEF,
  parameter int unsigned DataWidth   = rd_demux_pkg::DATA_WIDTH_DEF,
  parameter int unsigned LookBits    = rd_demux_pkg::LOOK_BITS_DEF
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  // master R ports, one slice each
  input  logic [NumMstPorts-1:0]           mst_r_valid_i,
  output logic [NumMstPorts-1:0]           mst_r_ready_o,
  input  logic [NumMstPorts*IdWidth-1:0]   mst_r_id_i,
  input  logic [NumMstPorts*DataWidth-1:0] mst_r_data_i,
  input  logic [NumMstPorts-1:0]           mst_r_last_i,
  // slave R port
  output logic                             slv_r_valid_o,
  input  logic                             slv_r_ready_i,
  output logic [IdWidth-1:0]               slv_r_id_o,
  output logic [DataWidth-1:0]             slv_r_data_o,
  output logic                             slv_r_last_o,
  // retire one read in the ID table
  output logic                             pop_o,
  output logic [LookBits-1:0]              pop_id_o
);
  import rd_demux_pkg::*;

  localparam int unsigned IdxWidth = (NumMstPorts > 1) ? $clog2(NumMstPorts) : SEL_WIDTH_MIN;

  // round-robin pointer and grant lock
  logic [IdxWidth-1:0] rr_q;
  logic                lock_q;
  logic [IdxWidth-1:0] lock_idx_q;
  // arbitration result
  logic [IdxWidth-1:0] arb_idx;
  logic [IdxWidth-1:0] gnt_idx;
  logic                xfer;

  // ------------------------------------------------
  // arbitration
  // ------------------------------------------------
  // first valid port at or after the pointer, pointer itself when none
  always_comb begin
    int unsigned cand;
    logic        found;
    found   = 1'b0;
    arb_idx = rr_q;
    for (int unsigned k = 0; k < NumMstPorts; k++) begin
      cand = (int'(rr_q) + k) % NumMstPorts;
      if (!found && mst_r_valid_i[cand]) begin
        found   = 1'b1;
        arb_idx = IdxWidth'(cand);
      end
    end
  end

  // a stalled beat keeps its grant
  assign gnt_idx = lock_q ? lock_idx_q : arb_idx;

  // ------------------------------------------------
  // beat forwarding
  // ------------------------------------------------
  assign slv_r_valid_o = mst_r_valid_i[gnt_idx];
  assign slv_r_id_o    = mst_r_id_i[gnt_idx*IdWidth +: IdWidth];
  assign slv_r_data_o  = mst_r_data_i[gnt_idx*DataWidth +: DataWidth];
  assign slv_r_last_o  = mst_r_last_i[gnt_idx];

  // ready only towards the granted master
  always_comb begin
    for (int i = 0; i < NumMstPorts; i++) begin
      mst_r_ready_o[i] = slv_r_valid_o && slv_r_ready_i && (gnt_idx == IdxWidth'(i));
    end
  end

  assign xfer     = slv_r_valid_o && slv_r_ready_i;
  assign pop_o    = xfer && slv_r_last_o;
  assign pop_id_o = slv_r_id_o[LookBits-1:0];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q     <= slv_r_valid_o && !slv_r_ready_i;
      lock_idx_q <= gnt_idx;
      // next priority goes to the port after the winner
      if (xfer) begin
        rr_q <= (gnt_idx == IdxWidth'(NumMstPorts - 1)) ? '0 : gnt_idx + 1'b1;
      end
    end
  end

  // stalled beat on the slave side is held unchanged
  a_r_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (slv_r_valid_o && !slv_r_ready_i) |=>
      (slv_r_valid_o && $stable(slv_r_id_o) && $stable(slv_r_data_o) &&
       $stable(slv_r_last_o)))
    else $error("R beat changed while the slave stalled");

endmodule

//--- hdl/rd_demux_top.sv
// read demultiplexer top level
// AR dispatcher, per-ID in-flight table and R arbiter

`timescale 1ns/1ps

module rd_demux_top #(
  parameter int unsigned NumMstPorts = rd_demux_pkg::NUM_MST_PORTS_DEF,
  parameter int unsigned IdWidth     = rd_demux_pkg::ID_WIDTH_DEF,
  parameter int unsigned LookBits    = rd_demux_pkg::LOOK_BITS_DEF,
  parameter int unsigned CntWidth    = rd_demux_pkg::CNT_WIDTH_DEF,
  parameter int unsigned AddrWidth   = rd_demux_pkg::ADDR_WIDTH_DEF,
  parameter int unsigned DataWidth   = rd_demux_pkg::DATA_WIDTH_DEF,
  localparam int unsigned SelWidth   = (NumMstPorts > 1) ? $clog2(NumMstPorts)
                                                         : rd_demux_pkg::SEL_WIDTH_MIN,
  localparam int unsigned LenWidth   = rd_demux_pkg::LEN_WIDTH
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  // slave AR
  input  logic                             slv_ar_valid_i,
  output logic                             slv_ar_ready_o,
  input  logic [IdWidth-1:0]               slv_ar_id_i,
  input  logic [AddrWidth-1:0]             slv_ar_addr_i,
  input  logic [LenWidth-1:0]              slv_ar_len_i,
  input  logic [SelWidth-1:0]              slv_ar_select_i,
  // slave R
  output logic                             slv_r_valid_o,
  input  logic                             slv_r_ready_i,
  output logic [IdWidth-1:0]               slv_r_id_o,
  output logic [DataWidth-1:0]             slv_r_data_o,
  output logic                             slv_r_last_o,
  // master AR, one slice per port
  output logic [NumMstPorts-1:0]           mst_ar_valid_o,
  input  logic [NumMstPorts-1:0]           mst_ar_ready_i,
  output logic [NumMstPorts*IdWidth-1:0]   mst_ar_id_o,
  output logic [NumMstPorts*AddrWidth-1:0] mst_ar_addr_o,
  output logic [NumMstPorts*LenWidth-1:0]  mst_ar_len_o,
  // master R, one slice per port
  input  logic [NumMstPorts-1:0]           mst_r_valid_i,
  output logic [NumMstPorts-1:0]           mst_r_ready_o,
  input  logic [NumMstPorts*IdWidth-1:0]   mst_r_id_i,
  input  logic [NumMstPorts*DataWidth-1:0] mst_r_data_i,
  input  logic [NumMstPorts-1:0]           mst_r_last_i
);
  import rd_demux_pkg::*;

  // table lookup for the AR in front
  logic [SelWidth-1:0] lookup_sel;
  logic                lookup_busy;
  logic                id_full;
  // table updates
  logic                ar_push;
  logic                r_pop;
  logic [LookBits-1:0] r_pop_id;

  // ------------------------------------------------
  // AR path
  // ------------------------------------------------
  ar_dispatch #(
    .NumMstPorts ( NumMstPorts ),
    .IdWidth     ( IdWidth     ),
    .AddrWidth   ( AddrWidth   )
  ) i_ar_dispatch (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .slv_ar_valid_i  ( slv_ar_valid_i  ),
    .slv_ar_ready_o  ( slv_ar_ready_o  ),
    .slv_ar_id_i     ( slv_ar_id_i     ),
    .slv_ar_addr_i   ( slv_ar_addr_i   ),
    .slv_ar_len_i    ( slv_ar_len_i    ),
    .slv_ar_select_i ( slv_ar_select_i ),
    .lookup_sel_i    ( lookup_sel      ),
    .lookup_busy_i   ( lookup_busy     ),
    .full_i          ( id_full         ),
    .push_o          ( ar_push         ),
    .mst_ar_valid_o  ( mst_ar_valid_o  ),
    .mst_ar_ready_i  ( mst_ar_ready_i  ),
    .mst_ar_id_o     ( mst_ar_id_o     ),
    .mst_ar_addr_o   ( mst_ar_addr_o   ),
    .mst_ar_len_o    ( mst_ar_len_o    )
  );

  // in-flight reads per low ID bits
  rd_id_table #(
    .NumMstPorts ( NumMstPorts ),
    .LookBits    ( LookBits    ),
    .CntWidth    ( CntWidth    )
  ) i_rd_id_table (
    .clk_i         ( clk_i                    ),
    .rst_n_i       ( rst_n_i                  ),
    .lookup_id_i   ( slv_ar_id_i[LookBits-1:0] ),
    .lookup_sel_o  ( lookup_sel               ),
    .lookup_busy_o ( lookup_busy              ),
    .full_o        ( id_full                  ),
    .push_i        ( ar_push                  ),
    .push_sel_i    ( slv_ar_select_i          ),
    .pop_i         ( r_pop                    ),
    .pop_id_i      ( r_pop_id                 )
  );

  // ------------------------------------------------
  // R path
  // ------------------------------------------------
  r_arbiter #(
    .NumMstPorts ( NumMstPorts ),
    .IdWidth     ( IdWidth     ),
    .DataWidth   ( DataWidth   ),
    .LookBits    ( LookBits    )
  ) i_r_arbiter (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .mst_r_valid_i ( mst_r_valid_i ),
    .mst_r_ready_o ( mst_r_ready_o ),
    .mst_r_id_i    ( mst_r_id_i    ),
    .mst_r_data_i  ( mst_r_data_i  ),
    .mst_r_last_i  ( mst_r_last_i  ),
    .slv_r_valid_o ( slv_r_valid_o ),
    .slv_r_ready_i ( slv_r_ready_i ),
    .slv_r_id_o    ( slv_r_id_o    ),
    .slv_r_data_o  ( slv_r_data_o  ),
    .slv_r_last_o  ( slv_r_last_o  ),
    .pop_o         ( r_pop         ),
    .pop_id_o      ( r_pop_id      )
  );

endmodule

//--- dv/tb_rd_demux.sv
// testbench for the read demultiplexer
// master port models, scoreboard with per-ID expected bursts, LFSR for delays

`timescale 1ns/1ps

module tb_rd_demux;
  import rd_demux_pkg::*;

  localparam int NP   = NUM_MST_PORTS_DEF;
  localparam int IW   = ID_WIDTH_DEF;
  localparam int AW   = ADDR_WIDTH_DEF;
  localparam int DW   = DATA_WIDTH_DEF;
  localparam int LW   = LEN_WIDTH;
  localparam int NT   = 1 << LOOK_BITS_DEF;
  localparam int MAXP = 64;
  localparam int TMO  = 2000;
  // cycles an AR must stay stalled before holds are released
  localparam int STALL_CYC = 20;

  logic clk_i;
  logic rst_n_i;
  logic slv_ar_valid_i;
  logic slv_ar_ready_o;
  logic [IW-1:0] slv_ar_id_i;
  logic [AW-1:0] slv_ar_addr_i;
  logic [LW-1:0] slv_ar_len_i;
  logic [1:0] slv_ar_select_i;
  logic slv_r_valid_o;
  logic slv_r_ready_i;
  logic [IW-1:0] slv_r_id_o;
  logic [DW-1:0] slv_r_data_o;
  logic slv_r_last_o;
  logic [NP-1:0] mst_ar_valid_o;
  logic [NP-1:0] mst_ar_ready_i;
  logic [NP*IW-1:0] mst_ar_id_o;
  logic [NP*AW-1:0] mst_ar_addr_o;
  logic [NP*LW-1:0] mst_ar_len_o;
  logic [NP-1:0] mst_r_valid_i;
  logic [NP-1:0] mst_r_ready_o;
  logic [NP*IW-1:0] mst_r_id_i;
  logic [NP*DW-1:0] mst_r_data_i;
  logic [NP-1:0] mst_r_last_i;

  // pattern words and the one on the slave AR
  logic [95:0] pats [MAXP];
  int cur_idx;
  int check_errs;
  int tmo_errs;
  logic [31:0] lfsr;
  logic [NP-1:0] hold;
  // master models, one AR queue per port
  logic [AW-1:0] mq_addr [NP][16];
  logic [LW-1:0] mq_len [NP][16];
  logic [IW-1:0] mq_id [NP][16];
  int mq_wr [NP];
  int mq_rd [NP];
  int mq_beat [NP];
  logic [NP-1:0] r_vld;
  // scoreboard, table mirror and expected bursts per full ID
  int cnt [NT];
  int csel [NT];
  int ex_pat [16][16];
  int ex_wr [16];
  int ex_rd [16];
  int ex_beat [16];
  int outstanding;
  // back-pressure and fairness history
  logic r_stalled;
  logic [IW-1:0] st_id;
  logic [DW-1:0] st_data;
  logic st_last;
  int prev_gnt;
  logic [NP-1:0] prev_vld;

  rd_demux_top i_rd_demux_top (.*);

  // ------------------------------------------------
  // helpers
  // ------------------------------------------------
  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic take_bit();
    lfsr = galois_step(lfsr);
    return lfsr[0];
  endfunction

  function automatic int pat_sel(input int k);
    return int'(pats[k][47:44]);
  endfunction

  function automatic int pat_port(input int k);
    return int'(pats[k][43:40]);
  endfunction

  function automatic int pat_len(input int k);
    return int'(pats[k][55:48]);
  endfunction

  task automatic report_value(input string name, input longint exp, input longint act);
    $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, act);
    check_errs++;
  endtask

  task automatic check_idle_outputs();
    if (mst_ar_valid_o != '0) report_value("mst_ar_valid_o", 0, mst_ar_valid_o);
    if (slv_r_valid_o != 1'b0) report_value("slv_r_valid_o", 0, slv_r_valid_o);
    if (slv_ar_ready_o != 1'b0) report_value("slv_ar_ready_o", 0, slv_ar_ready_o);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ------------------------------------------------
  // master models
  // ------------------------------------------------
  // new ready and R beats 10 ns after the edge, a raised valid waits for its transfer
  always begin
    @(posedge clk_i);
    #10;
    for (int p = 0; p < NP; p++) begin
      mst_ar_ready_i[p] = take_bit() | take_bit();
      if (!r_vld[p] && (mq_wr[p] != mq_rd[p]) && !hold[p] && take_bit()) begin
        r_vld[p] = 1'b1;
      end
      mst_r_valid_i[p]         = r_vld[p];
      mst_r_id_i[p*IW +: IW]   = mq_id[p][mq_rd[p] % 16];
      mst_r_data_i[p*DW +: DW] = mq_addr[p][mq_rd[p] % 16] + mq_beat[p];
      mst_r_last_i[p]          = (mq_beat[p] == mq_len[p][mq_rd[p] % 16]);
    end
    slv_r_ready_i = take_bit() | take_bit();
  end

  // transfers seen at the negative edge complete on the next rising edge
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      for (int p = 0; p < NP; p++) begin
        if (mst_ar_valid_o[p] && mst_ar_ready_i[p]) begin
          mq_addr[p][mq_wr[p] % 16] = mst_ar_addr_o[p*AW +: AW];
          mq_len[p][mq_wr[p] % 16]  = mst_ar_len_o[p*LW +: LW];
          mq_id[p][mq_wr[p] % 16]   = mst_ar_id_o[p*IW +: IW];
          mq_wr[p]++;
        end
        if (mst_r_valid_i[p] && mst_r_ready_o[p]) begin
          r_vld[p] = 1'b0;
          if (mst_r_last_i[p]) begin
            mq_rd[p]++;
            mq_beat[p] = 0;
          end else begin
            mq_beat[p]++;
          end
        end
      end
    end
  end

  // ------------------------------------------------
  // monitor and checks
  // ------------------------------------------------
  always @(negedge clk_i) begin : monitor
    logic admit;
    logic last_exp;
    logic [NP-1:0] exp_vld;
    logic [NP-1:0] exp_rdy;
    int l;
    int s;
    int g;
    int k;
    int ep;
    int id;
    if (rst_n_i) begin
      exp_vld = '0;
      l = int'(slv_ar_id_i) % NT;
      s = pat_port(cur_idx);
      if (slv_ar_valid_i) begin
        // admission from the ordering and full rules
        admit = 1'b1;
        for (int t = 0; t < NT; t++) begin
          if (cnt[t] == MAX_INFLIGHT_DEF) admit = 1'b0;
        end
        if (cnt[l] != 0 && csel[l] != pat_sel(cur_idx)) admit = 1'b0;
        if (admit) exp_vld[s] = 1'b1;
        if (slv_ar_ready_o != (admit && mst_ar_ready_i[s])) begin
          report_value("slv_ar_ready_o", admit && mst_ar_ready_i[s], slv_ar_ready_o);
        end
        if (admit && mst_ar_id_o[s*IW +: IW] != pats[cur_idx][91:88]) begin
          report_value("mst_ar_id_o", pats[cur_idx][91:88], mst_ar_id_o[s*IW +: IW]);
        end
        if (admit && mst_ar_addr_o[s*AW +: AW] != pats[cur_idx][87:56]) begin
          report_value("mst_ar_addr_o", pats[cur_idx][87:56], mst_ar_addr_o[s*AW +: AW]);
        end
        if (admit && mst_ar_len_o[s*LW +: LW] != pats[cur_idx][55:48]) begin
          report_value("mst_ar_len_o", pats[cur_idx][55:48], mst_ar_len_o[s*LW +: LW]);
        end
      end
      if (mst_ar_valid_o != exp_vld) report_value("mst_ar_valid_o", exp_vld, mst_ar_valid_o);
      // a stalled beat stays as it was
      if (r_stalled && !slv_r_valid_o) report_value("slv_r_valid_o", 1, 0);
      if (r_stalled && slv_r_id_o != st_id) report_value("slv_r_id_o", st_id, slv_r_id_o);
      if (r_stalled && slv_r_data_o != st_data) report_value("slv_r_data_o", st_data, slv_r_data_o);
      if (r_stalled && slv_r_last_o != st_last) report_value("slv_r_last_o", st_last, slv_r_last_o);
      r_stalled = slv_r_valid_o && !slv_r_ready_i;
      st_id     = slv_r_id_o;
      st_data   = slv_r_data_o;
      st_last   = slv_r_last_o;
      // no master sees R ready without a slave side transfer
      if (!(slv_r_valid_o && slv_r_ready_i) && mst_r_ready_o != '0) begin
        report_value("mst_r_ready_o", 0, mst_r_ready_o);
      end
      if (slv_r_valid_o && slv_r_ready_i) begin
        id = int'(slv_r_id_o);
        g  = -1;
        for (int p = 0; p < NP; p++) begin
          if (mst_r_ready_o[p]) g = p;
        end
        if (ex_wr[id] == ex_rd[id]) begin
          $display("R beat for ID %0d arrived at %0t with no read outstanding", id, $time);
          check_errs++;
        end else begin
          k        = ex_pat[id][ex_rd[id] % 16];
          ep       = pat_port(k);
          last_exp = (ex_beat[id] == pat_len(k));
          exp_rdy  = '0;
          exp_rdy[ep] = 1'b1;
          // only the port that serves this read sees ready
          if (mst_r_ready_o != exp_rdy) report_value("mst_r_ready_o", exp_rdy, mst_r_ready_o);
          if (slv_r_id_o != mst_r_id_i[ep*IW +: IW]) begin
            report_value("slv_r_id_o", mst_r_id_i[ep*IW +: IW], slv_r_id_o);
          end
          if (slv_r_data_o != pats[k][31:0] + ex_beat[id]) begin
            report_value("slv_r_data_o", pats[k][31:0] + ex_beat[id], slv_r_data_o);
          end
          if (slv_r_last_o != last_exp) report_value("slv_r_last_o", last_exp, slv_r_last_o);
          if (last_exp) begin
            ex_rd[id]++;
            ex_beat[id] = 0;
            outstanding--;
            cnt[id % NT]--;
          end else begin
            ex_beat[id]++;
          end
        end
        // a port still waiting since the last grant must win over a repeat
        for (int o = 0; o < NP; o++) begin
          if (prev_gnt == g && o != g && prev_vld[o] && mst_r_valid_i[o]) begin
            report_value("round-robin grant", o, g);
          end
        end
        prev_gnt = g;
        prev_vld = mst_r_valid_i;
      end
      if (slv_ar_valid_i && slv_ar_ready_o) begin
        id = int'(slv_ar_id_i);
        ex_pat[id][ex_wr[id] % 16] = cur_idx;
        ex_wr[id]++;
        outstanding++;
        cnt[l]++;
        csel[l] = pat_sel(cur_idx);
      end
    end
  end

  // ------------------------------------------------
  // stimulus
  // ------------------------------------------------
  initial begin
    int waited;
    int n_sent;
    logic done;
    logic [3:0] fl;
    rst_n_i = 1'b0;
    slv_ar_valid_i = 1'b0;
    slv_ar_id_i = '0;
    slv_ar_addr_i = '0;
    slv_ar_len_i = '0;
    slv_ar_select_i = '0;
    slv_r_ready_i = 1'b0;
    mst_ar_ready_i = '0;
    mst_r_valid_i = '0;
    mst_r_id_i = '0;
    mst_r_data_i = '0;
    mst_r_last_i = '0;
    lfsr = 32'h4fa981ae;
    hold = '0;
    r_vld = '0;
    r_stalled = 1'b0;
    prev_gnt = -1;
    prev_vld = '0;
    cur_idx = 0;
    check_errs = 0;
    tmo_errs = 0;
    outstanding = 0;
    n_sent = 0;
    for (int p = 0; p < NP; p++) begin
      mq_wr[p] = 0;
      mq_rd[p] = 0;
      mq_beat[p] = 0;
    end
    for (int t = 0; t < NT; t++) begin
      cnt[t] = 0;
      csel[t] = 0;
    end
    for (int i = 0; i < 16; i++) begin
      ex_wr[i] = 0;
      ex_rd[i] = 0;
      ex_beat[i] = 0;
    end
    for (int i = 0; i < MAXP; i++) begin
      pats[i] = '1;
    end
    $readmemh("dv/rd_demux_patterns.txt", pats);

    for (int c = 0; c < 16; c++) begin
      @(negedge clk_i);
      check_idle_outputs();
    end
    @(posedge clk_i);
    #10 rst_n_i = 1'b1;
    @(negedge clk_i);
    check_idle_outputs();

    for (int i = 0; i < MAXP; i++) begin
      fl = pats[i][95:92];
      if (fl == 4'hf) break;
      if (fl[0]) hold[pat_sel(i)] = 1'b1;
      @(posedge clk_i);
      #10;
      cur_idx         = i;
      slv_ar_valid_i  = 1'b1;
      slv_ar_id_i     = pats[i][91:88];
      slv_ar_addr_i   = pats[i][87:56];
      slv_ar_len_i    = pats[i][55:48];
      slv_ar_select_i = pats[i][45:44];
      n_sent++;
      done = 1'b0;
      waited = 0;
      while (!done && waited < TMO) begin
        @(negedge clk_i);
        waited++;
        if (slv_ar_ready_o) done = 1'b1;
        if (fl[2] && waited <= STALL_CYC && slv_ar_ready_o) begin
          report_value("slv_ar_ready_o while stalled", 0, 1);
        end
        if (fl[1] && waited == STALL_CYC) hold = '0;
      end
      if (!done) begin
        $display("AR of pattern %0d was never accepted", i);
        tmo_errs++;
        break;
      end
    end
    if (n_sent == 0) begin
      $display("no AR request was found in the pattern file");
      check_errs++;
    end
    @(posedge clk_i);
    #10 slv_ar_valid_i = 1'b0;

    // let every burst come back
    @(negedge clk_i);
    hold = '0;
    waited = 0;
    while (outstanding != 0 && waited < 5 * TMO) begin
      @(negedge clk_i);
      waited++;
    end
    if (outstanding != 0) begin
      $display("%0d reads were still outstanding when the drain timed out", outstanding);
      tmo_errs++;
    end

    $display("errors: %0d check, %0d timeout", check_errs, tmo_errs);
    if (check_errs == 0 && tmo_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- files.f
hdl/rd_demux_pkg.sv
hdl/ar_dispatch.sv
hdl/rd_id_table.sv
hdl/r_arbiter.sv
hdl/rd_demux_top.sv
dv/tb_rd_demux.sv

//--- dv/rd_demux_patterns.txt
// flags id addr len select exp_port rsv exp_first_data, one hex word per line
// flags: 1 hold R of the port, 2 release holds, 4 expect stall, f end of list
0_0_00001000_01_0_0_00_00001000
0_1_00002000_00_1_1_00_00002000
0_2_00003000_03_2_2_00_00003000
0_3_00004000_02_3_3_00_00004000
0_4_00005000_01_1_1_00_00005000
0_0_00006000_00_0_0_00_00006000
0_5_00007000_02_2_2_00_00007000
0_7_00008000_01_3_3_00_00008000
0_8_00009000_03_0_0_00_00009000
0_9_0000a000_00_1_1_00_0000a000
0_c_0000b000_02_2_2_00_0000b000
0_d_0000c000_01_3_3_00_0000c000
0_2_0000d000_03_2_2_00_0000d000
0_3_0000e000_00_0_0_00_0000e000
0_f_0000f000_02_1_1_00_0000f000
// ID 1 held on port 0, same port passes, other port stalls
1_1_00011000_02_0_0_00_00011000
0_1_00012000_01_0_0_00_00012000
6_1_00013000_00_2_2_00_00013000
// seven reads of ID 2 held on port 1, the eighth stalls on full
1_2_00021000_01_1_1_00_00021000
0_2_00022000_00_1_1_00_00022000
0_2_00023000_02_1_1_00_00023000
0_2_00024000_01_1_1_00_00024000
0_2_00025000_00_1_1_00_00025000
0_2_00026000_03_1_1_00_00026000
0_2_00027000_00_1_1_00_00027000
6_2_00028000_01_1_1_00_00028000
// mixed traffic after the stalls
0_0_00031000_01_3_3_00_00031000
0_1_00032000_02_0_0_00_00032000
0_3_00033000_00_2_2_00_00033000
0_2_00034000_01_1_1_00_00034000
0_6_00035000_03_3_3_00_00035000
0_a_00036000_02_0_0_00_00036000
f_0_00000000_00_0_0_00_00000000
